// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_dbg_unit
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SRCS     := $(shell cat $(FLIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dbg_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_decoder import dbg_pkg::*; #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // debugger bus
  input  wire logic                      req_i,
  input  wire logic                      we_i,
  input  wire logic [DBG_ADDR_W-1:0]     addr_i,
  input  wire logic [DBG_DATA_W-1:0]     wdata_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [DBG_DATA_W-1:0]          rdata_o,
  // status and debug register side
  input  wire logic                      halted_i,
  input  wire logic [DBG_DATA_W-1:0]     dbg_rdata_i,
  output logic                           regs_we_o,
  output logic [DBG_IDX_W-1:0]           regs_idx_o,
  output rdata_sel_e                     rd_region_o,
  // register file
  output logic                           regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_raddr_o,
  input  wire logic [DBG_DATA_W-1:0]     regfile_rdata_i,
  output logic                           regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_waddr_o,
  output logic [DBG_DATA_W-1:0]          regfile_wdata_o,
  // next-pc write
  output logic                           jump_req_o,
  output logic [DBG_DATA_W-1:0]          jump_addr_o
);

  logic [DBG_REGION_W-1:0] region;
  logic [DBG_IDX_W-1:0]    idx, idx_q;
  logic [DBG_DATA_W-1:0]   wdata_q;
  rdata_sel_e              rdata_sel_n, rdata_sel_q;
  logic                    rreq_n, rreq_q;
  logic                    jump_n, jump_q;
  logic                    regs_we_n, regs_we_q;
  logic                    rvalid_q;

  assign region = addr_i[DBG_REGION_MSB:DBG_REGION_LSB];
  assign idx    = addr_i[DBG_IDX_MSB:DBG_IDX_LSB];
  assign gnt_o  = req_i; // every request granted, denied ones too

  // --------------------------------------------------
  // request decode
  // --------------------------------------------------
  always_comb begin
    rdata_sel_n    = RD_NONE;
    rreq_n         = 1'b0;
    regfile_wreq_o = 1'b0;
    jump_n         = 1'b0;
    regs_we_n      = 1'b0;
    if (req_i) begin
      case (region)
        DBG_REGION_DBGA: begin
          if (we_i) regs_we_n = 1'b1; // applied next cycle from latched data
          else      rdata_sel_n = RD_DBGA;
        end
        DBG_REGION_DBGS: begin
          if (halted_i) begin // running: write dropped, read gives zero
            if (we_i) jump_n = (idx == DBG_IDX_NPC);
            else      rdata_sel_n = RD_DBGS;
          end
        end
        DBG_REGION_GPR: begin
          if (halted_i) begin
            if (we_i) begin
              regfile_wreq_o = 1'b1; // straight through, grant cycle
            end else begin
              rreq_n      = 1'b1;
              rdata_sel_n = RD_GPR;
            end
          end
        end
        default: ; // unmapped, reads as zero
      endcase
    end
  end

  // control flops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q    <= 1'b0;
      rdata_sel_q <= RD_NONE;
      rreq_q      <= 1'b0;
      jump_q      <= 1'b0;
      regs_we_q   <= 1'b0;
    end else begin
      rvalid_q    <= gnt_o; // rvalid exactly one cycle after gnt
      rdata_sel_q <= rdata_sel_n;
      rreq_q      <= rreq_n;
      jump_q      <= jump_n; // single-cycle pulse
      regs_we_q   <= regs_we_n;
    end
  end

  // payload, held from the granted request
  always_ff @(posedge clk) begin
    if (req_i) begin
      idx_q   <= idx;
      wdata_q <= wdata_i;
    end
  end

  // --------------------------------------------------
  // outputs and read mux
  // --------------------------------------------------
  assign rvalid_o        = rvalid_q;
  assign regs_we_o       = regs_we_q;
  assign regs_idx_o      = idx_q;
  assign rd_region_o     = rdata_sel_q;
  assign regfile_rreq_o  = rreq_q;
  assign regfile_raddr_o = idx_q[REG_ADDR_WIDTH-1:0];
  assign regfile_waddr_o = idx[REG_ADDR_WIDTH-1:0];
  assign regfile_wdata_o = wdata_i;
  assign jump_req_o      = jump_q;
  assign jump_addr_o     = wdata_q;

  always_comb begin
    case (rdata_sel_q)
      RD_GPR:           rdata_o = regfile_rdata_i; // rf answers in same cycle
      RD_DBGA, RD_DBGS: rdata_o = dbg_rdata_i;
      default:          rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: dbg_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// debug registers <-> halt controller
interface dbg_ctrl_if import dbg_pkg::*;
  ();

  // requests from the debug registers
  logic                   halt_req;   // one cycle, ctrl write with halt bit
  logic                   resume_req; // one cycle, ctrl write without halt bit
  logic                   ssth_clear; // hit register write, bit 0

  // status back from the halt fsm
  logic                   halted;
  logic                   ssth;       // single step hit
  logic [DBG_CAUSE_W-1:0] cause;

  modport regs (
    output halt_req, resume_req, ssth_clear,
    input  halted, ssth, cause
  );

  modport halt (
    input  halt_req, resume_req, ssth_clear,
    output halted, ssth, cause
  );

endinterface

`default_nettype wire

// File: dbg_halt_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_halt_ctrl import dbg_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   halt_i,      // external debugger halt
  input  wire logic                   resume_i,
  input  wire logic                   trap_i,      // core hit a trap
  input  wire logic [DBG_CAUSE_W-1:0] exc_cause_i,
  input  wire logic                   ack_i,       // core is quiet now
  input  wire logic                   sste_i,      // single step enabled
  output logic                        halt_req_o,
  output logic                        stall_o,
  dbg_ctrl_if.halt                    ctrl
);

  typedef enum logic [1:0] {RUNNING, HALT_REQ, HALTED} halt_state_e;

  halt_state_e            state_q, state_n;
  logic [DBG_CAUSE_W-1:0] cause_q, cause_n;
  logic                   ssth_q, ssth_n;
  logic                   resume;
  logic                   halted;

  assign resume = ctrl.resume_req | resume_i;

  // --------------------------------------------------
  // halt fsm
  // --------------------------------------------------
  always_comb begin
    state_n    = state_q;
    cause_n    = cause_q;
    ssth_n     = ssth_q;
    halt_req_o = 1'b0;
    stall_o    = 1'b0;
    halted     = 1'b0;
    case (state_q)
      RUNNING: begin
        ssth_n = 1'b0; // hit only lives across a halt
        if (ctrl.halt_req | halt_i | trap_i) begin
          halt_req_o = 1'b1; // same cycle as the cause
          state_n    = HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = sste_i;
          end else begin
            cause_n = DBG_CAUSE_HALT;
          end
        end
      end
      HALT_REQ: begin
        halt_req_o = 1'b1; // held until ack
        if (ack_i)  state_n = HALTED;
        if (resume) state_n = RUNNING; // resume wins
      end
      HALTED: begin
        halted  = 1'b1;
        stall_o = 1'b1;
        if (resume) begin
          state_n = RUNNING;
          stall_o = 1'b0; // release core right away
        end
      end
      default: state_n = RUNNING;
    endcase
    if (ctrl.ssth_clear) ssth_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUNNING;
      cause_q <= DBG_CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  // status to debug registers
  assign ctrl.halted = halted;
  assign ctrl.ssth   = ssth_q;
  assign ctrl.cause  = cause_q;

endmodule

`default_nettype wire

// File: dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  // --------------------------------------------------
  // bus widths and address fields
  // --------------------------------------------------
  localparam int DBG_ADDR_W     = 15;
  localparam int DBG_DATA_W     = 32;

  localparam int DBG_REGION_LSB = 8;
  localparam int DBG_REGION_MSB = 13;
  localparam int DBG_REGION_W   = DBG_REGION_MSB - DBG_REGION_LSB + 1;
  localparam int DBG_IDX_LSB    = 2;  // word addressed
  localparam int DBG_IDX_MSB    = 6;
  localparam int DBG_IDX_W      = DBG_IDX_MSB - DBG_IDX_LSB + 1;

  // region codes, addr[13:8]
  localparam logic [DBG_REGION_W-1:0] DBG_REGION_DBGA = 6'h00; // always accessible
  localparam logic [DBG_REGION_W-1:0] DBG_REGION_DBGS = 6'h20; // halted only
  localparam logic [DBG_REGION_W-1:0] DBG_REGION_GPR  = 6'h04;

  // register indices, addr[6:2]
  localparam logic [DBG_IDX_W-1:0] DBG_IDX_CTRL  = 5'd0;
  localparam logic [DBG_IDX_W-1:0] DBG_IDX_HIT   = 5'd1;
  localparam logic [DBG_IDX_W-1:0] DBG_IDX_IE    = 5'd2;
  localparam logic [DBG_IDX_W-1:0] DBG_IDX_CAUSE = 5'd3;
  localparam logic [DBG_IDX_W-1:0] DBG_IDX_NPC   = 5'd0;
  localparam logic [DBG_IDX_W-1:0] DBG_IDX_PPC   = 5'd1;

  // --------------------------------------------------
  // settings bits toward the core
  // --------------------------------------------------
  localparam int DBG_SETS_W     = 5;
  localparam int DBG_SETS_SSTE  = 0; // single step
  localparam int DBG_SETS_ECALL = 1;
  localparam int DBG_SETS_ELSU  = 2; // load/store misaligned or fault
  localparam int DBG_SETS_EBRK  = 3;
  localparam int DBG_SETS_EILL  = 4;

  localparam int DBG_CTRL_HALT_BIT = 16;

  // cause register
  localparam int DBG_CAUSE_W = 6;
  localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_HALT = 6'h1F;

  // source of read data in the rvalid cycle
  typedef enum logic [1:0] {RD_NONE, RD_GPR, RD_DBGA, RD_DBGS} rdata_sel_e;

endpackage

`default_nettype wire

// File: dbg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_regs import dbg_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  regs_we_i,   // latched write to dbga region
  input  wire logic [DBG_IDX_W-1:0]  regs_idx_i,
  input  wire rdata_sel_e            rd_region_i,
  input  wire logic [DBG_DATA_W-1:0] wdata_i,
  input  wire logic                  sleeping_i,
  input  wire logic [DBG_DATA_W-1:0] pc_if_i,
  input  wire logic [DBG_DATA_W-1:0] pc_id_i,
  output logic [DBG_DATA_W-1:0]      dbg_rdata_o,
  output logic [DBG_SETS_W-1:0]      settings_o,
  dbg_ctrl_if.regs                   ctrl
);

  logic [DBG_SETS_W-1:0] settings_q, settings_n;
  logic                  halt_req, resume_req, ssth_clear;

  // --------------------------------------------------
  // write decode
  // --------------------------------------------------
  always_comb begin
    settings_n = settings_q;
    halt_req   = 1'b0;
    resume_req = 1'b0;
    ssth_clear = 1'b0;
    if (regs_we_i) begin
      case (regs_idx_i)
        DBG_IDX_CTRL: begin
          // halt bit set stops, clear resumes
          if (wdata_i[DBG_CTRL_HALT_BIT]) halt_req   = !ctrl.halted;
          else                            resume_req = ctrl.halted;
          settings_n[DBG_SETS_SSTE] = wdata_i[0];
        end
        DBG_IDX_HIT: ssth_clear = wdata_i[0];
        DBG_IDX_IE: begin
          settings_n[DBG_SETS_ECALL] = wdata_i[11];
          settings_n[DBG_SETS_ELSU]  = wdata_i[7] | wdata_i[5]; // one shared bit
          settings_n[DBG_SETS_EBRK]  = wdata_i[3];
          settings_n[DBG_SETS_EILL]  = wdata_i[2];
        end
        default: ; // cause is read only
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) settings_q <= '0;
    else        settings_q <= settings_n;
  end

  assign settings_o      = settings_q;
  assign ctrl.halt_req   = halt_req;
  assign ctrl.resume_req = resume_req;
  assign ctrl.ssth_clear = ssth_clear;

  // --------------------------------------------------
  // read value, rvalid cycle
  // --------------------------------------------------
  always_comb begin
    dbg_rdata_o = '0;
    case (rd_region_i)
      RD_DBGA: begin
        case (regs_idx_i)
          DBG_IDX_CTRL: begin
            dbg_rdata_o[DBG_CTRL_HALT_BIT] = ctrl.halted;
            dbg_rdata_o[0]                 = settings_q[DBG_SETS_SSTE];
          end
          DBG_IDX_HIT: begin
            dbg_rdata_o[16] = sleeping_i;
            dbg_rdata_o[0]  = ctrl.ssth;
          end
          DBG_IDX_IE: begin
            dbg_rdata_o[11] = settings_q[DBG_SETS_ECALL];
            dbg_rdata_o[7]  = settings_q[DBG_SETS_ELSU];
            dbg_rdata_o[5]  = settings_q[DBG_SETS_ELSU];
            dbg_rdata_o[3]  = settings_q[DBG_SETS_EBRK];
            dbg_rdata_o[2]  = settings_q[DBG_SETS_EILL];
          end
          // msb of cause is the interrupt flag
          DBG_IDX_CAUSE: dbg_rdata_o = {ctrl.cause[DBG_CAUSE_W-1], 26'b0,
                                        ctrl.cause[DBG_CAUSE_W-2:0]};
          default: ; // bp ctrl and the rest read zero
        endcase
      end
      RD_DBGS: begin
        case (regs_idx_i)
          DBG_IDX_NPC: dbg_rdata_o = pc_if_i;
          DBG_IDX_PPC: dbg_rdata_o = pc_id_i;
          default:     ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: dbg_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_unit import dbg_pkg::*; #(
  parameter int REG_ADDR_WIDTH = 5 // 4 for rv32e
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // debugger bus
  input  wire logic                      req_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  input  wire logic [DBG_ADDR_W-1:0]     addr_i,
  input  wire logic                      we_i,
  input  wire logic [DBG_DATA_W-1:0]     wdata_i,
  output logic [DBG_DATA_W-1:0]          rdata_o,
  output logic                           halted_o,
  input  wire logic                      halt_i,
  input  wire logic                      resume_i,
  // core side
  output logic [DBG_SETS_W-1:0]          settings_o,
  input  wire logic                      trap_i,
  input  wire logic [DBG_CAUSE_W-1:0]    exc_cause_i,
  output logic                           stall_o,
  output logic                           halt_req_o,
  input  wire logic                      ack_i,
  // register file ports
  output logic                           regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_raddr_o,
  input  wire logic [DBG_DATA_W-1:0]     regfile_rdata_i,
  output logic                           regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_waddr_o,
  output logic [DBG_DATA_W-1:0]          regfile_wdata_o,
  // pcs, sleep, jump
  input  wire logic [DBG_DATA_W-1:0]     pc_if_i,
  input  wire logic [DBG_DATA_W-1:0]     pc_id_i,
  input  wire logic                      sleeping_i,
  output logic                           jump_req_o,
  output logic [DBG_DATA_W-1:0]          jump_addr_o
);

  logic                  regs_we;
  logic [DBG_IDX_W-1:0]  regs_idx;
  rdata_sel_e            rd_region;
  logic [DBG_DATA_W-1:0] dbg_rdata;
  logic [DBG_DATA_W-1:0] wdata_q; // latched bus data, jump target and reg writes

  dbg_ctrl_if ctrl_if0 ();

  assign halted_o    = ctrl_if0.halted;
  assign jump_addr_o = wdata_q;

  dbg_bus_decoder #(
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) bus_dec0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .we_i            (we_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .gnt_o           (gnt_o),
    .rvalid_o        (rvalid_o),
    .rdata_o         (rdata_o),
    .halted_i        (ctrl_if0.halted),
    .dbg_rdata_i     (dbg_rdata),
    .regs_we_o       (regs_we),
    .regs_idx_o      (regs_idx),
    .rd_region_o     (rd_region),
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_raddr_o (regfile_raddr_o),
    .regfile_rdata_i (regfile_rdata_i),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (wdata_q)
  );

  dbg_regs regs0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .regs_we_i   (regs_we),
    .regs_idx_i  (regs_idx),
    .rd_region_i (rd_region),
    .wdata_i     (wdata_q),
    .sleeping_i  (sleeping_i),
    .pc_if_i     (pc_if_i),
    .pc_id_i     (pc_id_i),
    .dbg_rdata_o (dbg_rdata),
    .settings_o  (settings_o),
    .ctrl        (ctrl_if0.regs)
  );

  dbg_halt_ctrl halt0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .halt_i      (halt_i),
    .resume_i    (resume_i),
    .trap_i      (trap_i),
    .exc_cause_i (exc_cause_i),
    .ack_i       (ack_i),
    .sste_i      (settings_o[DBG_SETS_SSTE]),
    .halt_req_o  (halt_req_o),
    .stall_o     (stall_o),
    .ctrl        (ctrl_if0.halt)
  );

endmodule

`default_nettype wire

// File: dbg_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_unit_checker (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic req_i,
  input wire logic gnt_i,
  input wire logic rvalid_i,
  input wire logic stall_i,
  input wire logic halted_i,
  input wire logic jump_req_i
);

  // --------------------------------------------------
  // bus handshake
  // --------------------------------------------------
  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    gnt_i |=> rvalid_i) else $error("rvalid missing after grant");

  rvalid_only_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> $past(gnt_i)) else $error("rvalid without a grant");

  gnt_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    gnt_i == req_i) else $error("grant differs from request");

  // halt side
  stall_needs_halted: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |-> halted_i) else $error("stall while not halted");

  jump_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    jump_req_i |=> !jump_req_i) else $error("jump request longer than one cycle");

endmodule

`default_nettype wire

// File: flist.f
dbg_pkg.sv
dbg_ctrl_if.sv
dbg_bus_decoder.sv
dbg_regs.sv
dbg_halt_ctrl.sv
dbg_unit.sv
dbg_unit_checker.sv
tb_dbg_unit.sv

// File: tb_dbg_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_unit import dbg_pkg::*; ();

  localparam int          WAIT_LIMIT = 64;            // cycles per wait
  localparam logic [31:0] PC_IF      = 32'h0000_1a40; // fixed core pcs
  localparam logic [31:0] PC_ID      = 32'h0000_1a3c;

  // signals a wait can watch
  localparam int SIG_RVALID = 0;
  localparam int SIG_HREQ   = 1;
  localparam int SIG_HALTED = 2;
  localparam int SIG_JUMP   = 3;

  typedef enum {K_WR, K_RD, K_SETS, K_GPR, K_HALTED, K_RUNNING, K_JUMP} chk_e;

  typedef struct {
    string                 name;
    logic                  we;
    logic [DBG_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
    logic                  trap;  // pulse trap_i instead of a bus access
    logic [5:0]            cause;
    logic [31:0]           exp;
    chk_e                  kind;
  } row_t;

  logic                   clk, rst_n;
  logic                   req_i, we_i, gnt_o, rvalid_o;
  logic [DBG_ADDR_W-1:0]  addr_i;
  logic [31:0]            wdata_i, rdata_o;
  logic                   halted_o, halt_i, resume_i, trap_i, ack_i;
  logic [DBG_SETS_W-1:0]  settings_o;
  logic [DBG_CAUSE_W-1:0] exc_cause_i;
  logic                   stall_o, halt_req_o, sleeping_i;
  logic                   regfile_rreq_o, regfile_wreq_o, jump_req_o;
  logic [4:0]             regfile_raddr_o, regfile_waddr_o;
  logic [31:0]            regfile_rdata_i, regfile_wdata_o, jump_addr_o;
  logic [31:0]            pc_if_i, pc_id_i;

  row_t   rows[$];
  integer seed = 17;
  int     checks = 0;
  int     errors = 0;
  logic   timed_out = 1'b0;

  assign pc_if_i = PC_IF;
  assign pc_id_i = PC_ID;

  dbg_unit #(
    .REG_ADDR_WIDTH (5)
  ) dut0 (.*);

  bind dbg_unit dbg_unit_checker chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .gnt_i      (gnt_o),
    .rvalid_i   (rvalid_o),
    .stall_i    (stall_o),
    .halted_i   (halted_o),
    .jump_req_i (jump_req_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns
  end

  // --------------------------------------------------
  // core model, register file and halt ack
  // --------------------------------------------------
  logic [31:0] rf [32];
  logic        ack_next, wr_pend;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  int          hreq_cnt;

  assign regfile_rdata_i = regfile_rreq_o ? rf[regfile_raddr_o] : '0; // comb answer on request

  initial begin : core_model
    ack_i    = 1'b0;
    ack_next = 1'b0;
    wr_pend  = 1'b0;
    hreq_cnt = 0;
    for (int i = 0; i < 32; i++) begin
      rf[i] = $random(seed);
    end
    forever begin
      @(negedge clk);
      ack_i = ack_next;
      #1; // outputs settled
      if (halt_req_o) begin
        hreq_cnt++;
      end else begin
        hreq_cnt = 0;
      end
      ack_next = halt_req_o && (hreq_cnt >= 2); // ack two cycles late
      wr_pend  = regfile_wreq_o;
      wr_addr  = regfile_waddr_o;
      wr_data  = regfile_wdata_o;
      @(posedge clk);
      if (wr_pend) rf[wr_addr] = wr_data;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [DBG_ADDR_W-1:0] reg_addr(input logic [5:0] region,
                                                     input logic [4:0] idx);
    return {1'b0, region, 1'b0, idx, 2'b00};
  endfunction

  function automatic logic probe(input int sig);
    case (sig)
      SIG_RVALID: return rvalid_o;
      SIG_HREQ:   return halt_req_o;
      SIG_HALTED: return halted_o;
      SIG_JUMP:   return jump_req_o;
      default:    return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // polls at each falling edge
  task automatic wait_level(input int sig, input logic level, input string what);
    int cnt;
    cnt = 0;
    while (probe(sig) !== level && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (probe(sig) !== level) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: %s did not go to %b within %0d cycles", what, level, WAIT_LIMIT);
    end
  endtask

  task automatic bus_access(input logic we, input logic [DBG_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    @(negedge clk);
    req_i = 1'b0; // single beat
    we_i  = 1'b0;
    wait_level(SIG_RVALID, 1'b1, "rvalid");
    rdata = rdata_o;
  endtask

  task automatic pulse_trap(input logic [5:0] cause);
    @(negedge clk);
    trap_i      = 1'b1;
    exc_cause_i = cause;
    @(negedge clk);
    trap_i = 1'b0;
  endtask

  task automatic add_row(input string name, input logic we, input logic [DBG_ADDR_W-1:0] addr,
                         input logic [31:0] wdata, input logic trap, input logic [5:0] cause,
                         input logic [31:0] exp, input chk_e kind);
    row_t r;
    r = '{name, we, addr, wdata, trap, cause, exp, kind};
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] rdata;
    rdata = '0;
    if (r.trap) pulse_trap(r.cause);
    else        bus_access(r.we, r.addr, r.wdata, rdata);
    if (!timed_out) begin
      case (r.kind)
        K_RD:   check_value(r.name, r.exp, rdata);
        K_SETS: begin
          @(negedge clk); // settings land one cycle after the write
          check_value(r.name, r.exp, {27'd0, settings_o});
        end
        K_GPR:  check_value(r.name, r.exp, rf[r.addr[DBG_IDX_MSB:DBG_IDX_LSB]]);
        K_HALTED: begin
          wait_level(SIG_HREQ, 1'b1, "halt_req");
          wait_level(SIG_HALTED, 1'b1, "halted");
          check_value({r.name, "_stall"}, 32'd1, {31'd0, stall_o});
        end
        K_RUNNING: begin
          wait_level(SIG_HALTED, 1'b0, "halted release");
          check_value({r.name, "_stall"}, 32'd0, {31'd0, stall_o});
        end
        K_JUMP: begin
          wait_level(SIG_JUMP, 1'b1, "jump_req");
          check_value(r.name, r.exp, jump_addr_o);
          @(negedge clk);
          check_value({r.name, "_pulse"}, 32'd0, {31'd0, jump_req_o}); // one cycle only
        end
        default: ;
      endcase
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    logic [31:0] w_ie, w_gpr_run, w_gpr, w_jmp, tmp, ie_exp, sets_exp;
    logic [5:0]  trap_cause;
    logic [4:0]  idx_a, idx_b;
    logic        elsu;
    rst_n       = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    halt_i      = 1'b0;
    resume_i    = 1'b0;
    trap_i      = 1'b0;
    exc_cause_i = '0;
    sleeping_i  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("rst_stall", 32'd0, {31'd0, stall_o});
    check_value("rst_halted", 32'd0, {31'd0, halted_o});
    check_value("rst_halt_req", 32'd0, {31'd0, halt_req_o});
    check_value("rst_settings", 32'd0, {27'd0, settings_o});
    check_value("rst_jump", 32'd0, {31'd0, jump_req_o});
    check_value("rst_rreq", 32'd0, {31'd0, regfile_rreq_o});

    w_ie       = $random(seed);
    w_gpr_run  = $random(seed);
    w_gpr      = $random(seed);
    w_jmp      = $random(seed);
    tmp        = $random(seed);
    trap_cause = tmp[5:0];
    tmp        = $random(seed);
    idx_a      = tmp[4:0];
    idx_b      = idx_a ^ 5'h1;

    // ie keeps 11, 7|5, 3, 2
    elsu     = w_ie[7] | w_ie[5];
    ie_exp   = '0;
    ie_exp[11] = w_ie[11];
    ie_exp[7]  = elsu;
    ie_exp[5]  = elsu;
    ie_exp[3]  = w_ie[3];
    ie_exp[2]  = w_ie[2];
    sets_exp = '0;
    sets_exp[DBG_SETS_ECALL] = w_ie[11];
    sets_exp[DBG_SETS_ELSU]  = elsu;
    sets_exp[DBG_SETS_EBRK]  = w_ie[3];
    sets_exp[DBG_SETS_EILL]  = w_ie[2];

    add_row("rst_ctrl", 0, reg_addr(6'h00, 5'd0), 0, 0, 0, 32'd0, K_RD);
    add_row("rst_hit", 0, reg_addr(6'h00, 5'd1), 0, 0, 0, 32'd0, K_RD);
    add_row("rst_cause", 0, reg_addr(6'h00, 5'd3), 0, 0, 0, 32'h1f, K_RD);
    add_row("ie_write", 1, reg_addr(6'h00, 5'd2), w_ie, 0, 0, sets_exp, K_SETS);
    add_row("ie_read", 0, reg_addr(6'h00, 5'd2), 0, 0, 0, ie_exp, K_RD);
    add_row("gpr_wr_running", 1, reg_addr(6'h04, idx_a), w_gpr_run, 0, 0, rf[idx_a], K_GPR);
    add_row("gpr_rd_running", 0, reg_addr(6'h04, idx_b), 0, 0, 0, 32'd0, K_RD);
    add_row("halt_write", 1, reg_addr(6'h00, 5'd0), 32'h0001_0000, 0, 0, 0, K_HALTED);
    add_row("ctrl_halted", 0, reg_addr(6'h00, 5'd0), 0, 0, 0, 32'h0001_0000, K_RD);
    add_row("gpr_wr_halted", 1, reg_addr(6'h04, idx_a), w_gpr, 0, 0, w_gpr, K_GPR);
    add_row("gpr_rd_written", 0, reg_addr(6'h04, idx_a), 0, 0, 0, w_gpr, K_RD);
    add_row("gpr_rd_other", 0, reg_addr(6'h04, idx_b), 0, 0, 0, rf[idx_b], K_RD);
    add_row("npc_read", 0, reg_addr(6'h20, 5'd0), 0, 0, 0, PC_IF, K_RD);
    add_row("ppc_read", 0, reg_addr(6'h20, 5'd1), 0, 0, 0, PC_ID, K_RD);
    add_row("npc_write", 1, reg_addr(6'h20, 5'd0), w_jmp, 0, 0, w_jmp, K_JUMP);
    add_row("resume_sste", 1, reg_addr(6'h00, 5'd0), 32'd1, 0, 0, 0, K_RUNNING);
    add_row("trap_halt", 0, '0, 0, 1, trap_cause, 0, K_HALTED);
    add_row("cause_trap", 0, reg_addr(6'h00, 5'd3), 0, 0, 0,
            {trap_cause[5], 26'd0, trap_cause[4:0]}, K_RD);
    add_row("hit_set", 0, reg_addr(6'h00, 5'd1), 0, 0, 0, 32'd1, K_RD);
    add_row("hit_clear", 1, reg_addr(6'h00, 5'd1), 32'd1, 0, 0, 0, K_WR);
    add_row("hit_cleared", 0, reg_addr(6'h00, 5'd1), 0, 0, 0, 32'd0, K_RD);
    add_row("resume_end", 1, reg_addr(6'h00, 5'd0), 32'd0, 0, 0, 0, K_RUNNING);
    add_row("ctrl_running", 0, reg_addr(6'h00, 5'd0), 0, 0, 0, 32'd0, K_RD);

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      apply_row(rows[i]);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
